//--- common/dacPkg.sv
package dacPkg;

	////////////////////////////////////////
	// Sizes
	////////////////////////////////////////
	localparam int FrameBits    = 32;
	localparam int CodeBits     = 12;
	localparam int ChannelCount = 4;
	localparam int RegDataBits  = 32;
	localparam int RegAddrBits  = 3;
	localparam int IndexBits    = $clog2(ChannelCount);

	// SPI clock half period in DAC_CLR cycles
	localparam int SckHalf       = 2;
	localparam int HalfCountBits = $clog2(SckHalf + 1);
	localparam int BitCountBits  = $clog2(FrameBits);

	// Clear pulse length after reset
	localparam int ClearCycles    = 8;
	localparam int ClearCountBits = $clog2(ClearCycles + 1);

	////////////////////////////////////////
	// DAC command word
	////////////////////////////////////////
	localparam logic [3:0] CmdWriteUpdate = 4'd3;
	localparam logic [3:0] AddrAll        = 4'd15;

	////////////////////////////////////////
	// Host register map
	////////////////////////////////////////
	localparam logic [RegAddrBits-1:0] RegChan0     = 3'd0;
	localparam logic [RegAddrBits-1:0] RegChan1     = 3'd1;
	localparam logic [RegAddrBits-1:0] RegChan2     = 3'd2;
	localparam logic [RegAddrBits-1:0] RegChan3     = 3'd3;
	localparam logic [RegAddrBits-1:0] RegUpdate    = 3'd4;
	localparam logic [RegAddrBits-1:0] RegEcho      = 3'd5;
	localparam logic [RegAddrBits-1:0] RegStatus    = 3'd6;
	localparam logic [RegAddrBits-1:0] RegBroadcast = 3'd7;

	// Sequencer states
	localparam int                      SeqStateBits = 2;
	localparam logic [SeqStateBits-1:0] SeqClear     = 2'd0;
	localparam logic [SeqStateBits-1:0] SeqIdle      = 2'd1;
	localparam logic [SeqStateBits-1:0] SeqStart     = 2'd2;
	localparam logic [SeqStateBits-1:0] SeqWait      = 2'd3;

	// One SPI frame, seen as a bit stream or as DAC fields
	typedef union packed {
		logic [FrameBits-1:0] raw;
		struct packed {
			logic [7:0]          prefix;
			logic [3:0]          command;
			logic [3:0]          address;
			logic [CodeBits-1:0] code;
			logic [3:0]          tail;
		} fields;
	} dacFrame_u;

endpackage

//--- verilog/dacRegs.sv
module dacRegs
	import dacPkg::*;
(
	input  logic                                  DAC_CLR,
	input  logic                                  reseted,
	input  logic                                  regWrite,
	input  logic [RegAddrBits-1:0]                regAddr,
	input  logic [RegDataBits-1:0]                regWriteData,
	input  logic                                  doneChannel,
	input  logic [IndexBits-1:0]                  doneIndex,
	input  logic                                  doneBroadcast,
	input  logic                                  busy,
	input  logic                                  frameDone,
	input  dacFrame_u                             frameIn,
	output logic [RegDataBits-1:0]                regReadData,
	output logic [ChannelCount-1:0][CodeBits-1:0] chanCodes,
	output logic [ChannelCount-1:0]               pendingMask,
	output logic                                  broadcastPending,
	output logic [CodeBits-1:0]                   broadcastCode
);

	logic [ChannelCount-1:0] setMask;
	logic [ChannelCount-1:0] clearMask;
	logic                    writeUpdate;
	logic                    writeBroadcast;
	logic                    writeChannel;
	dacFrame_u               echoWord;

	assign writeUpdate    = regWrite && (regAddr == RegUpdate);
	assign writeBroadcast = regWrite && (regAddr == RegBroadcast);
	assign writeChannel   = regWrite && (regAddr <= RegChan3);

	// Bits set by the host and cleared by finished frames
	always_comb begin
		setMask   = '0;
		clearMask = '0;
		if (writeUpdate) begin
			setMask = regWriteData[ChannelCount-1:0];
		end
		if (doneChannel) begin
			clearMask[doneIndex] = 1'b1;
		end
	end

	////////////////////////////////////////
	// Pending work
	////////////////////////////////////////
	always_ff @(posedge DAC_CLR) begin
		if (reseted) begin
			pendingMask      <= '0;
			broadcastPending <= 1'b0;
		end else begin
			// Host write wins over a clear of the same bit
			pendingMask <= (pendingMask & ~clearMask) | setMask;
			if (writeBroadcast) begin
				broadcastPending <= 1'b1;
			end else if (doneBroadcast) begin
				broadcastPending <= 1'b0;
			end
		end
	end

	////////////////////////////////////////
	// Codes and echo
	////////////////////////////////////////
	always_ff @(posedge DAC_CLR) begin
		if (writeChannel) begin
			chanCodes[regAddr[IndexBits-1:0]] <= regWriteData[CodeBits-1:0];
		end
		if (writeBroadcast) begin
			broadcastCode <= regWriteData[CodeBits-1:0];
		end
		// Word shifted back by the DAC during the last frame
		if (frameDone) begin
			echoWord <= frameIn;
		end
	end

	// Host readback
	always_comb begin
		regReadData = '0;
		case (regAddr)
			RegChan0, RegChan1, RegChan2, RegChan3: begin
				regReadData[CodeBits-1:0] = chanCodes[regAddr[IndexBits-1:0]];
			end
			RegUpdate: begin
				regReadData[ChannelCount-1:0] = pendingMask;
			end
			RegEcho: begin
				regReadData = echoWord.raw;
			end
			RegStatus: begin
				regReadData[0]   = busy;
				regReadData[7:4] = pendingMask;
				regReadData[8]   = broadcastPending;
			end
			RegBroadcast: begin
				regReadData[CodeBits-1:0] = broadcastCode;
			end
			default: begin
				regReadData = '0;
			end
		endcase
	end

endmodule

//--- verilog/dacSequencer.sv
module dacSequencer
	import dacPkg::*;
(
	input  logic                                  DAC_CLR,
	input  logic                                  reseted,
	input  logic [ChannelCount-1:0][CodeBits-1:0] chanCodes,
	input  logic [ChannelCount-1:0]               pendingMask,
	input  logic                                  broadcastPending,
	input  logic [CodeBits-1:0]                   broadcastCode,
	input  logic                                  frameDone,
	input  logic                                  shifterIdle,
	output logic                                  dacClearN,
	output logic                                  busy,
	output logic                                  frameStart,
	output dacFrame_u                             frameOut,
	output logic                                  doneChannel,
	output logic [IndexBits-1:0]                  doneIndex,
	output logic                                  doneBroadcast
);

	logic [SeqStateBits-1:0]   state;
	logic [ClearCountBits-1:0] clearCount;
	logic                      anyWork;
	logic                      selFound;
	logic [IndexBits-1:0]      selIndex;
	logic [IndexBits-1:0]      curIndex;
	logic                      curBroadcast;

	assign anyWork = (|pendingMask) || broadcastPending;

	// Lowest pending channel wins
	always_comb begin
		selFound = 1'b0;
		selIndex = '0;
		for (int i = ChannelCount - 1; i >= 0; i--) begin
			if (pendingMask[i]) begin
				selFound = 1'b1;
				selIndex = IndexBits'(i);
			end
		end
	end

	// Frame for the selected channel, else the broadcast
	always_comb begin
		frameOut                = '0;
		frameOut.fields.command = CmdWriteUpdate;
		if (selFound) begin
			frameOut.fields.address = 4'(selIndex);
			frameOut.fields.code    = chanCodes[selIndex];
		end else begin
			frameOut.fields.address = AddrAll;
			frameOut.fields.code    = broadcastCode;
		end
	end

	assign frameStart = (state == SeqStart) && shifterIdle && anyWork;

	// Done pulses in the frameDone cycle so the mask is fresh for the next start
	assign doneChannel   = (state == SeqWait) && frameDone && !curBroadcast;
	assign doneBroadcast = (state == SeqWait) && frameDone && curBroadcast;
	assign doneIndex     = curIndex;

	assign busy = (state != SeqIdle) || anyWork;

	////////////////////////////////////////
	// Control FSM
	////////////////////////////////////////
	always_ff @(posedge DAC_CLR) begin
		if (reseted) begin
			state        <= SeqClear;
			clearCount   <= '0;
			dacClearN    <= 1'b0;
			curBroadcast <= 1'b0;
		end else begin
			case (state)
				SeqClear: begin
					if (clearCount == ClearCountBits'(ClearCycles - 1)) begin
						dacClearN <= 1'b1;
						state     <= SeqIdle;
					end else begin
						clearCount <= clearCount + 1'b1;
					end
				end
				SeqIdle: begin
					if (anyWork) begin
						state <= SeqStart;
					end
				end
				SeqStart: begin
					// Nothing left after the last frame
					if (!anyWork) begin
						state <= SeqIdle;
					end else if (shifterIdle) begin
						state        <= SeqWait;
						curBroadcast <= !selFound;
					end
				end
				SeqWait: begin
					if (frameDone) begin
						state <= SeqStart;
					end
				end
				default: begin
					state <= SeqIdle;
				end
			endcase
		end
	end

	// Channel of the frame in flight
	always_ff @(posedge DAC_CLR) begin
		if (frameStart) begin
			curIndex <= selIndex;
		end
	end

endmodule

//--- spiLink/spiShifter.sv
module spiShifter
	import dacPkg::*;
(
	input  logic      DAC_CLR,
	input  logic      reseted,
	input  logic      frameStart,
	input  dacFrame_u frameOut,
	input  logic      dacOut,
	output logic      spiSck,
	output logic      spiMosi,
	output logic      dacCs,
	output logic      shifterIdle,
	output logic      frameDone,
	output dacFrame_u frameIn
);

	logic                     active;
	logic                     tailPhase;
	logic [HalfCountBits-1:0] halfCount;
	logic [BitCountBits-1:0]  bitCount;
	logic                     halfEnd;
	logic                     sckRise;
	logic                     sckFall;
	logic [FrameBits-1:0]     txShift;
	logic [FrameBits-1:0]     rxShift;

	assign halfEnd = (halfCount == HalfCountBits'(SckHalf - 1));
	assign sckRise = active && !tailPhase && halfEnd && !spiSck;
	assign sckFall = active && !tailPhase && halfEnd && spiSck;

	assign shifterIdle = !active;
	assign frameIn.raw = rxShift;

	////////////////////////////////////////
	// Frame timing
	////////////////////////////////////////
	always_ff @(posedge DAC_CLR) begin
		if (reseted) begin
			active    <= 1'b0;
			tailPhase <= 1'b0;
			halfCount <= '0;
			bitCount  <= '0;
			dacCs     <= 1'b1;
			spiSck    <= 1'b0;
			spiMosi   <= 1'b0;
			frameDone <= 1'b0;
		end else begin
			frameDone <= 1'b0;
			if (!active) begin
				if (frameStart) begin
					active    <= 1'b1;
					tailPhase <= 1'b0;
					halfCount <= '0;
					bitCount  <= '0;
					dacCs     <= 1'b0;
					spiMosi   <= frameOut.raw[FrameBits-1];
				end
			end else if (!halfEnd) begin
				halfCount <= halfCount + 1'b1;
			end else begin
				halfCount <= '0;
				if (tailPhase) begin
					// CS hold after the last falling edge
					active    <= 1'b0;
					tailPhase <= 1'b0;
					dacCs     <= 1'b1;
					spiMosi   <= 1'b0;
					frameDone <= 1'b1;
				end else if (!spiSck) begin
					spiSck <= 1'b1;
				end else begin
					spiSck <= 1'b0;
					if (bitCount == BitCountBits'(FrameBits - 1)) begin
						tailPhase <= 1'b1;
					end else begin
						bitCount <= bitCount + 1'b1;
						// Next bit while SCK is low
						spiMosi  <= txShift[FrameBits-2];
					end
				end
			end
		end
	end

	// Shift registers, MSB first in both directions
	always_ff @(posedge DAC_CLR) begin
		if (!active && frameStart) begin
			txShift <= frameOut.raw;
		end else if (sckFall) begin
			txShift <= {txShift[FrameBits-2:0], 1'b0};
		end
		if (sckRise) begin
			rxShift <= {rxShift[FrameBits-2:0], dacOut};
		end
	end

endmodule

//--- verilog/dacController.sv
module dacController
	import dacPkg::*;
(
	input  logic                   DAC_CLR,
	input  logic                   reseted,
	input  logic                   regWrite,
	input  logic [RegAddrBits-1:0] regAddr,
	input  logic [RegDataBits-1:0] regWriteData,
	input  logic                   dacOut,
	output logic [RegDataBits-1:0] regReadData,
	output logic                   busy,
	output logic                   spiSck,
	output logic                   spiMosi,
	output logic                   dacCs,
	output logic                   dacClearN
);

	logic [ChannelCount-1:0][CodeBits-1:0] chanCodes;
	logic [ChannelCount-1:0]               pendingMask;
	logic                                  broadcastPending;
	logic [CodeBits-1:0]                   broadcastCode;
	logic                                  doneChannel;
	logic [IndexBits-1:0]                  doneIndex;
	logic                                  doneBroadcast;
	logic                                  frameStart;
	dacFrame_u                             frameOut;
	logic                                  frameDone;
	dacFrame_u                             frameIn;
	logic                                  shifterIdle;

	// Host registers
	dacRegs dacRegs_inst (
		.DAC_CLR          (DAC_CLR),
		.reseted          (reseted),
		.regWrite         (regWrite),
		.regAddr          (regAddr),
		.regWriteData     (regWriteData),
		.doneChannel      (doneChannel),
		.doneIndex        (doneIndex),
		.doneBroadcast    (doneBroadcast),
		.busy             (busy),
		.frameDone        (frameDone),
		.frameIn          (frameIn),
		.regReadData      (regReadData),
		.chanCodes        (chanCodes),
		.pendingMask      (pendingMask),
		.broadcastPending (broadcastPending),
		.broadcastCode    (broadcastCode)
	);

	// Clear pulse and frame scheduling
	dacSequencer dacSequencer_inst (
		.DAC_CLR          (DAC_CLR),
		.reseted          (reseted),
		.chanCodes        (chanCodes),
		.pendingMask      (pendingMask),
		.broadcastPending (broadcastPending),
		.broadcastCode    (broadcastCode),
		.frameDone        (frameDone),
		.shifterIdle      (shifterIdle),
		.dacClearN        (dacClearN),
		.busy             (busy),
		.frameStart       (frameStart),
		.frameOut         (frameOut),
		.doneChannel      (doneChannel),
		.doneIndex        (doneIndex),
		.doneBroadcast    (doneBroadcast)
	);

	// Serial link to the DAC
	spiShifter spiShifter_inst (
		.DAC_CLR     (DAC_CLR),
		.reseted     (reseted),
		.frameStart  (frameStart),
		.frameOut    (frameOut),
		.dacOut      (dacOut),
		.spiSck      (spiSck),
		.spiMosi     (spiMosi),
		.dacCs       (dacCs),
		.shifterIdle (shifterIdle),
		.frameDone   (frameDone),
		.frameIn     (frameIn)
	);

endmodule

//--- testbench/dacModel.sv
module dacModel
	import dacPkg::*;
(
	input  logic      spiSck,
	input  logic      spiMosi,
	input  logic      dacCs,
	input  logic      dacClearN,
	output logic      dacOut,
	output dacFrame_u lastFrame,
	output dacFrame_u echoedFrame,
	output int        frameCount,
	output int        errorCount
);

	logic [FrameBits-1:0] rxShift;
	logic [FrameBits-1:0] txShift;
	logic [FrameBits-1:0] prevFrame;
	int                   bitCount;
	logic                 inFrame;
	logic                 clearDone;

	initial begin
		dacOut      = 1'b0;
		lastFrame   = '0;
		echoedFrame = '0;
		frameCount  = 0;
		errorCount  = 0;
		rxShift     = '0;
		txShift     = '0;
		prevFrame   = '0;
		bitCount    = 0;
		inFrame     = 1'b0;
		clearDone   = 1'b0;
	end

	// Clear pulse has ended
	always @(posedge dacClearN) begin
		clearDone = 1'b1;
	end

	always @(negedge dacClearN) begin
		if (dacCs === 1'b0) begin
			$display("Clear line went low during a frame at %0t", $time);
			errorCount++;
		end
	end

	////////////////////////////////////////
	// Frame start, echo the previous frame
	////////////////////////////////////////
	always @(negedge dacCs) begin
		if (!clearDone) begin
			$display("Chip select went low before the clear pulse at %0t", $time);
			errorCount++;
		end
		if (dacClearN !== 1'b1) begin
			$display("Chip select went low while the clear line was low at %0t", $time);
			errorCount++;
		end
		inFrame  = 1'b1;
		bitCount = 0;
		txShift  = prevFrame;
		dacOut   = txShift[FrameBits-1];
	end

	// DAC samples on rising SCK
	always @(posedge spiSck) begin
		if (inFrame) begin
			rxShift = {rxShift[FrameBits-2:0], spiMosi};
			bitCount++;
		end
	end

	// Echo bit changes while SCK is low
	always @(negedge spiSck) begin
		if (inFrame) begin
			txShift = {txShift[FrameBits-2:0], 1'b0};
			dacOut  = txShift[FrameBits-1];
		end
	end

	always @(posedge dacCs) begin
		if (inFrame) begin
			if (bitCount != FrameBits) begin
				$display("Frame ended after %0d SCK edges instead of %0d at %0t",
					bitCount, FrameBits, $time);
				errorCount++;
			end
			inFrame         = 1'b0;
			dacOut          = 1'b0;
			echoedFrame.raw = prevFrame;
			prevFrame       = rxShift;
			lastFrame.raw   = rxShift;
			frameCount++;
		end
	end

endmodule

//--- testbench/dacControllerTb.sv
module dacControllerTb
	import dacPkg::*;
();

	// Cycles from frame start to frame done
	localparam int FrameCycles = 1 + FrameBits * 2 * SckHalf + SckHalf;
	localparam int Rounds      = 6;
	localparam int FrameLimit  = ChannelCount + 1 + Rounds * ChannelCount;
	localparam int CycleLimit  = FrameLimit * FrameCycles + 2000;

	logic                   DAC_CLR;
	logic                   reseted;
	logic                   regWrite;
	logic [RegAddrBits-1:0] regAddr;
	logic [RegDataBits-1:0] regWriteData;
	logic                   dacOut;
	logic [RegDataBits-1:0] regReadData;
	logic                   busy;
	logic                   spiSck;
	logic                   spiMosi;
	logic                   dacCs;
	logic                   dacClearN;

	dacFrame_u lastFrame;
	dacFrame_u echoedFrame;
	int        frameCount;
	int        modelErrors;

	dacFrame_u           expectedQueue[$];
	logic [CodeBits-1:0] codes[ChannelCount];
	logic [7:0]          lfsrState = 8'd62;
	int                  frameErrors = 0;
	int                  wordErrors = 0;
	int                  timingErrors = 0;
	int                  expectedTotal = 0;
	int                  cycleCount = 0;
	int                  lastStart = 0;
	logic                startSeen = 1'b0;

	dacController dacController_inst (
		.DAC_CLR      (DAC_CLR),
		.reseted      (reseted),
		.regWrite     (regWrite),
		.regAddr      (regAddr),
		.regWriteData (regWriteData),
		.dacOut       (dacOut),
		.regReadData  (regReadData),
		.busy         (busy),
		.spiSck       (spiSck),
		.spiMosi      (spiMosi),
		.dacCs        (dacCs),
		.dacClearN    (dacClearN)
	);

	dacModel dacModel_inst (
		.spiSck      (spiSck),
		.spiMosi     (spiMosi),
		.dacCs       (dacCs),
		.dacClearN   (dacClearN),
		.dacOut      (dacOut),
		.lastFrame   (lastFrame),
		.echoedFrame (echoedFrame),
		.frameCount  (frameCount),
		.errorCount  (modelErrors)
	);

	initial begin
		DAC_CLR = 1'b0;
		forever #10 DAC_CLR = ~DAC_CLR;
	end

	////////////////////////////////////////
	// Reference model and compare tasks
	////////////////////////////////////////
	function automatic dacFrame_u referenceFrame(input logic isBroadcast,
		input logic [IndexBits-1:0] index, input logic [CodeBits-1:0] code);
		dacFrame_u frame;
		frame                = '0;
		frame.fields.command = CmdWriteUpdate;
		frame.fields.address = isBroadcast ? AddrAll : 4'(index);
		frame.fields.code    = code;
		return frame;
	endfunction

	// x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsrNext(input logic [7:0] state);
		return {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
	endfunction

	task automatic drawBits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsrState = lfsrNext(lfsrState);
			value     = {value[30:0], lfsrState[0]};
		end
	endtask

	task automatic checkFrame(input string name, input dacFrame_u actual,
		input dacFrame_u expected);
		if (actual !== expected) begin
			$display("FAILED at %0t: %s = %h, expected %h", $time, name, actual, expected);
			frameErrors++;
		end
	endtask

	task automatic checkWord(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAILED at %0t: %s = %h, expected %h", $time, name, actual, expected);
			wordErrors++;
		end
	endtask

	// Channel frames in ascending index order
	task automatic queueMask(input logic [ChannelCount-1:0] mask);
		for (int i = 0; i < ChannelCount; i++) begin
			if (mask[i]) begin
				expectedQueue.push_back(referenceFrame(1'b0, IndexBits'(i), codes[i]));
				expectedTotal++;
			end
		end
	endtask

	////////////////////////////////////////
	// Host bus tasks
	////////////////////////////////////////
	task automatic writeReg(input logic [RegAddrBits-1:0] addr, input logic [31:0] data);
		@(posedge DAC_CLR);
		regWrite     <= 1'b1;
		regAddr      <= addr;
		regWriteData <= data;
		@(posedge DAC_CLR);
		regWrite     <= 1'b0;
	endtask

	task automatic readReg(input logic [RegAddrBits-1:0] addr, output logic [31:0] data);
		@(posedge DAC_CLR);
		regAddr <= addr;
		@(negedge DAC_CLR);
		data = regReadData;
	endtask

	// Waits for the next frame, then reads the echo register
	task automatic waitFrameEcho();
		int          target;
		logic [31:0] data;
		target = frameCount + 1;
		wait (frameCount >= target);
		readReg(RegEcho, data);
		checkWord("regReadData(RegEcho)", data, echoedFrame.raw);
	endtask

	task automatic waitIdle();
		logic idle;
		idle = 1'b0;
		@(posedge DAC_CLR);
		regAddr <= RegStatus;
		while (!idle) begin
			@(negedge DAC_CLR);
			if (!busy) begin
				idle = 1'b1;
				checkWord("regReadData(RegStatus)", regReadData, '0);
			end
		end
	endtask

	// Frames from the model against the expected order
	initial begin
		forever begin
			@(frameCount);
			@(negedge DAC_CLR);
			if (expectedQueue.size() == 0) begin
				$display("Unexpected frame %h from the DUT at %0t", lastFrame, $time);
				frameErrors++;
			end else begin
				checkFrame("dacModel frame", lastFrame, expectedQueue.pop_front());
			end
		end
	end

	// Spacing between frame starts
	always @(negedge dacCs) begin
		if (startSeen && (cycleCount - lastStart) < FrameCycles) begin
			$display("Frame started %0d cycles after the previous one, minimum is %0d",
				cycleCount - lastStart, FrameCycles);
			timingErrors++;
		end
		startSeen = 1'b1;
		lastStart = cycleCount;
	end

	always @(posedge DAC_CLR) begin
		cycleCount++;
		if (cycleCount >= CycleLimit) begin
			$display("Run stopped by timeout after %0d cycles", cycleCount);
			$display("Errors: %0d frame, %0d word, %0d timing, %0d model",
				frameErrors, wordErrors, timingErrors, modelErrors);
			$display("Test failures found");
			$finish;
		end
	end

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////
	initial begin
		logic [31:0]             value;
		logic [31:0]             data;
		logic [ChannelCount-1:0] mask1;
		logic [ChannelCount-1:0] mask2;
		logic [ChannelCount-1:0] rest;
		int                      first;
		int                      lowCycles;
		int                      totalErrors;

		reseted      = 1'b1;
		regWrite     = 1'b0;
		regAddr      = '0;
		regWriteData = '0;
		repeat (10) @(posedge DAC_CLR);
		reseted <= 1'b0;

		// Clear pulse after reset
		lowCycles = 0;
		@(negedge DAC_CLR);
		while (dacClearN === 1'b0) begin
			checkWord("dacCs", 32'(dacCs), 32'd1);
			checkWord("busy", 32'(busy), 32'd1);
			lowCycles++;
			@(negedge DAC_CLR);
		end
		checkWord("dacClearN low cycles", lowCycles, ClearCycles);
		checkWord("busy", 32'(busy), 32'd0);

		// Channel codes, readback and full update
		for (int i = 0; i < ChannelCount; i++) begin
			drawBits(CodeBits, value);
			codes[i] = value[CodeBits-1:0];
			writeReg(RegAddrBits'(i), value);
		end
		for (int i = 0; i < ChannelCount; i++) begin
			readReg(RegAddrBits'(i), data);
			checkWord($sformatf("regReadData(RegChan%0d)", i), data, 32'(codes[i]));
		end
		queueMask(4'hF);
		writeReg(RegUpdate, 32'hF);
		repeat (ChannelCount) waitFrameEcho();
		waitIdle();

		// Broadcast frame
		drawBits(CodeBits, value);
		expectedQueue.push_back(referenceFrame(1'b1, '0, value[CodeBits-1:0]));
		expectedTotal++;
		writeReg(RegBroadcast, value);
		readReg(RegBroadcast, data);
		checkWord("regReadData(RegBroadcast)", data, 32'(value[CodeBits-1:0]));
		waitFrameEcho();
		waitIdle();

		// Second mask lands while the first frame is in flight
		for (int r = 0; r < Rounds; r++) begin
			drawBits(ChannelCount, value);
			mask1 = value[ChannelCount-1:0];
			if (mask1 == '0) begin
				mask1 = 4'b0001;
			end
			drawBits(ChannelCount, value);
			mask2 = value[ChannelCount-1:0];
			first = 0;
			for (int i = ChannelCount - 1; i >= 0; i--) begin
				if (mask1[i]) begin
					first = i;
				end
			end
			expectedQueue.push_back(referenceFrame(1'b0, IndexBits'(first), codes[first]));
			expectedTotal++;
			writeReg(RegUpdate, 32'(mask1));
			// Pending bits in 7:4 and busy in bit 0 before the frame starts
			readReg(RegStatus, data);
			checkWord("regReadData(RegStatus)", data, (32'(mask1) << 4) | 32'd1);
			@(negedge dacCs);
			writeReg(RegUpdate, 32'(mask2));
			rest = (mask1 | mask2) & ~(4'b0001 << first);
			queueMask(rest);
			waitIdle();
		end

		repeat (4) @(negedge DAC_CLR);
		if (expectedQueue.size() != 0) begin
			$display("%0d expected frames never arrived", expectedQueue.size());
			frameErrors++;
		end
		checkWord("frameCount", frameCount, expectedTotal);

		totalErrors = frameErrors + wordErrors + timingErrors + modelErrors;
		$display("Errors: %0d frame, %0d word, %0d timing, %0d model",
			frameErrors, wordErrors, timingErrors, modelErrors);
		if (totalErrors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- verilog.f
common/dacPkg.sv
verilog/dacRegs.sv
verilog/dacSequencer.sv
spiLink/spiShifter.sv
verilog/dacController.sv
testbench/dacModel.sv
testbench/dacControllerTb.sv
